/* Bender.yml */
package:
  name: ifu

sources:
  - common/ifu_pkg.sv
  - hdl/pc_reg.sv
  - hdl/fetch_fsm.sv
  - hdl/fetch_credit.sv
  - btb/btb.sv
  - iq/inst_queue.sv
  - hdl/ifu_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/ifu_assert.sv
      - tb/ifu_tb.sv

/* btb/btb.sv */
`timescale 1ns/1ps

module btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  ifu_pkg::addr_t  lookup_pc_i,
  output logic            pred_valid_o,
  output ifu_pkg::addr_t  pred_pc_o,
  input  logic            upd_valid_i,
  input  ifu_pkg::addr_t  upd_src_pc_i,
  input  ifu_pkg::addr_t  upd_target_i
);

  import ifu_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 32 - IDX_W - 2;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  logic [BTB_ENTRIES-1:0] valid_q;
  tag_t                   tag_q [BTB_ENTRIES];
  addr_t                  target_q [BTB_ENTRIES];

  idx_t lk_idx;
  tag_t lk_tag;
  idx_t up_idx;
  tag_t up_tag;

  // word aligned, so bits [1:0] carry nothing
  assign lk_idx = lookup_pc_i[IDX_W+1:2];
  assign lk_tag = lookup_pc_i[31:IDX_W+2];
  assign up_idx = upd_src_pc_i[IDX_W+1:2];
  assign up_tag = upd_src_pc_i[31:IDX_W+2];

  // combinational lookup
  assign pred_valid_o = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign pred_pc_o    = target_q[lk_idx];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  // tag and target array
  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[up_idx]    <= up_tag;
      target_q[up_idx] <= upd_target_i;  // last resolution wins
    end
  end

endmodule

/* common/ifu_pkg.sv */
package ifu_pkg;

  // instruction address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // first fetch after reset and after a flush
  localparam addr_t PC_RESET_ADDR = 32'h8000_0000;

  // fetch FSM states
  typedef enum logic [1:0] {
    RESET_S = 2'd0,  // first cycle out of reset, no request
    RUN_S   = 2'd1,  // normal fetching
    HOLD_S  = 2'd2,  // no credit or stalled
    KILL_S  = 2'd3   // redirect in progress
  } fetch_state_e;

endpackage

/* hdl/fetch_credit.sv */
`timescale 1ns/1ps

module fetch_credit #(
  parameter int IQ_DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic req_i,       // request issued this cycle
  input  logic enq_i,       // response written to the queue
  input  logic drop_i,      // response thrown away
  input  logic deq_i,       // real pop, never on empty
  input  logic redirect_i,
  output logic credit_ok_o
);

  localparam int CW = $clog2(IQ_DEPTH + 1);

  logic [CW-1:0] inflight_q;  // requests waiting for their response
  logic [CW-1:0] occ_q;       // slots holding an instruction
  logic [CW:0]   used;

  assign used = {1'b0, inflight_q} + {1'b0, occ_q};

  // queue is emptied on redirect, so there is always room then
  assign credit_ok_o = redirect_i | (used < (CW + 1)'(IQ_DEPTH));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
      occ_q      <= '0;
    end else if (redirect_i) begin
      inflight_q <= CW'(req_i);  // only the target fetch remains
      occ_q      <= '0;
    end else begin
      inflight_q <= inflight_q + CW'(req_i) - CW'(enq_i | drop_i);
      occ_q      <= occ_q + CW'(enq_i) - CW'(deq_i);
    end
  end

endmodule

/* hdl/fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm (
  input  logic clk,
  input  logic arst_n_i,
  input  logic credit_ok_i,
  input  logic stall_i,
  input  logic redirect_i,
  input  logic resp_valid_i,
  output logic req_en_o,
  output logic drop_resp_o
);

  import ifu_pkg::*;

  fetch_state_e state_q, state_d;
  logic         req_q;  // a request went out last cycle

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET_S: state_d = RUN_S;
      RUN_S: begin
        if (redirect_i) begin
          state_d = KILL_S;
        end else if (!credit_ok_i || stall_i) begin
          state_d = HOLD_S;
        end
      end
      HOLD_S: begin
        if (redirect_i) begin
          state_d = KILL_S;
        end else if (credit_ok_i && !stall_i) begin
          state_d = RUN_S;
        end
      end
      KILL_S: begin
        if (redirect_i) begin
          state_d = KILL_S;  // back to back redirect
        end else if (credit_ok_i && !stall_i) begin
          state_d = RUN_S;
        end else begin
          state_d = HOLD_S;
        end
      end
      default: state_d = RESET_S;
    endcase
  end

  // a redirect requests in its own cycle whenever credit allows
  always_comb begin
    if (state_q == RESET_S) begin
      req_en_o = 1'b0;
    end else if (redirect_i) begin
      req_en_o = credit_ok_i;
    end else begin
      req_en_o = (state_q == RUN_S) & credit_ok_i & ~stall_i;
    end
  end

  // response of the redirect cycle is stale; in KILL_S only the target fetch survives
  assign drop_resp_o = resp_valid_i &
                       (redirect_i | ((state_q == KILL_S) & ~req_q));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RESET_S;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= req_en_o;
    end
  end

endmodule

/* hdl/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top #(
  parameter int IQ_DEPTH    = 4,
  parameter int BTB_ENTRIES = 16
) (
  input  logic            clk,
  input  logic            arst_n_i,
  // instruction memory
  output logic            read_req_o,
  output ifu_pkg::addr_t  pc_next_o,
  input  ifu_pkg::inst_t  inst_i,
  input  logic            inst_valid_i,
  // decode
  output logic            iq_valid_o,
  output ifu_pkg::inst_t  iq_inst_o,
  output ifu_pkg::addr_t  iq_pc_o,
  input  logic            deq_i,
  // control
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            trap_valid_i,
  input  ifu_pkg::addr_t  trap_pc_i,
  input  logic            br_valid_i,
  input  ifu_pkg::addr_t  br_target_i,
  input  ifu_pkg::addr_t  br_src_pc_i
);

  import ifu_pkg::*;

  addr_t pc_cur;
  addr_t bpu_pc;
  addr_t req_pc_q;   // address of the response arriving now
  logic  bpu_valid;
  logic  req_en;
  logic  credit_ok;
  logic  drop_resp;
  logic  redirect;
  logic  enq;
  logic  drop;
  logic  pop;

  assign redirect = flush_i | trap_valid_i | br_valid_i;
  assign enq      = inst_valid_i & ~drop_resp;
  assign drop     = inst_valid_i & drop_resp;
  assign pop      = deq_i & iq_valid_o;

  always_ff @(posedge clk) begin
    if (read_req_o) req_pc_q <= pc_next_o;
  end

  pc_reg u_pc_reg (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_en_i     (req_en),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .trap_valid_i (trap_valid_i),
    .trap_pc_i    (trap_pc_i),
    .br_valid_i   (br_valid_i),
    .br_target_i  (br_target_i),
    .bpu_valid_i  (bpu_valid),
    .bpu_pc_i     (bpu_pc),
    .pc_next_o    (pc_next_o),
    .read_req_o   (read_req_o),
    .pc_o         (pc_cur)
  );

  fetch_fsm u_fetch_fsm (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .credit_ok_i  (credit_ok),
    .stall_i      (stall_i),
    .redirect_i   (redirect),
    .resp_valid_i (inst_valid_i),
    .req_en_o     (req_en),
    .drop_resp_o  (drop_resp)
  );

  fetch_credit #(.IQ_DEPTH(IQ_DEPTH)) u_fetch_credit (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (read_req_o),
    .enq_i       (enq),
    .drop_i      (drop),
    .deq_i       (pop),
    .redirect_i  (redirect),
    .credit_ok_o (credit_ok)
  );

  btb #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .lookup_pc_i  (pc_cur),
    .pred_valid_o (bpu_valid),
    .pred_pc_o    (bpu_pc),
    .upd_valid_i  (br_valid_i),  // trained by taken branches
    .upd_src_pc_i (br_src_pc_i),
    .upd_target_i (br_target_i)
  );

  inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_inst_queue (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .enq_i      (enq),
    .enq_inst_i (inst_i),
    .enq_pc_i   (req_pc_q),
    .deq_i      (deq_i),
    .flush_i    (redirect),
    .valid_o    (iq_valid_o),
    .inst_o     (iq_inst_o),
    .pc_o       (iq_pc_o),
    .full_o     ()
  );

endmodule

/* hdl/pc_reg.sv */
`timescale 1ns/1ps

module pc_reg (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            req_en_i,      // from fetch FSM
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            trap_valid_i,
  input  ifu_pkg::addr_t  trap_pc_i,
  input  logic            br_valid_i,
  input  ifu_pkg::addr_t  br_target_i,
  input  logic            bpu_valid_i,
  input  ifu_pkg::addr_t  bpu_pc_i,
  output ifu_pkg::addr_t  pc_next_o,     // fetch address of this cycle
  output logic            read_req_o,
  output ifu_pkg::addr_t  pc_o           // last fetched address
);

  import ifu_pkg::*;

  // one word below the reset address, so the first PC+4 lands on it
  localparam addr_t PC_INIT = PC_RESET_ADDR - 32'd4;

  addr_t pc_q;
  addr_t pc_sel;
  logic  redirect;
  logic  pc_upd;

  assign redirect = flush_i | trap_valid_i | br_valid_i;

  // flush > trap > branch > predictor > sequential
  always_comb begin
    if (flush_i) begin
      pc_sel = PC_RESET_ADDR;
    end else if (trap_valid_i) begin
      pc_sel = trap_pc_i;
    end else if (br_valid_i) begin
      pc_sel = br_target_i;
    end else if (bpu_valid_i) begin
      pc_sel = bpu_pc_i;
    end else begin
      pc_sel = pc_q + 32'd4;
    end
  end

  // a redirect goes out even under stall, otherwise the target is lost
  assign pc_upd = req_en_i & (~stall_i | redirect);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= PC_INIT;
    end else if (pc_upd) begin
      pc_q <= pc_sel;
    end
  end

  // held: show the current PC
  assign pc_next_o  = pc_upd ? pc_sel : pc_q;
  assign read_req_o = pc_upd;
  assign pc_o       = pc_q;

endmodule

/* ifu.f */
common/ifu_pkg.sv
hdl/pc_reg.sv
hdl/fetch_fsm.sv
hdl/fetch_credit.sv
btb/btb.sv
iq/inst_queue.sv
hdl/ifu_top.sv
tb/tb_clkgen.sv
tb/ifu_assert.sv
tb/ifu_tb.sv

/* iq/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
  parameter int IQ_DEPTH = 4
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            enq_i,
  input  ifu_pkg::inst_t  enq_inst_i,
  input  ifu_pkg::addr_t  enq_pc_i,
  input  logic            deq_i,
  input  logic            flush_i,
  output logic            valid_o,
  output ifu_pkg::inst_t  inst_o,
  output ifu_pkg::addr_t  pc_o,
  output logic            full_o
);

  localparam int PW = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int CW = $clog2(IQ_DEPTH + 1);

  ifu_pkg::inst_t inst_mem [IQ_DEPTH];
  ifu_pkg::addr_t pc_mem   [IQ_DEPTH];

  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_enq;
  logic          do_deq;

  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == CW'(IQ_DEPTH));

  assign do_enq = enq_i & ~full_o & ~flush_i;
  assign do_deq = deq_i & valid_o & ~flush_i;  // pop on empty ignored

  // depth need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    if (p == PW'(IQ_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_enq) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_deq) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CW'(do_enq) - CW'(do_deq);
    end
  end

  always_ff @(posedge clk) begin
    if (do_enq) begin
      inst_mem[wr_ptr_q] <= enq_inst_i;
      pc_mem[wr_ptr_q]   <= enq_pc_i;
    end
  end

  assign inst_o = inst_mem[rd_ptr_q];
  assign pc_o   = pc_mem[rd_ptr_q];

endmodule

/* tb/ifu_assert.sv */
`timescale 1ns/1ps

module ifu_assert (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            read_req_i,
  input  ifu_pkg::addr_t  pc_next_i,
  input  logic            bpu_valid_i,
  input  logic            stall_i,
  input  logic            flush_i,
  input  logic            trap_valid_i,
  input  ifu_pkg::addr_t  trap_pc_i,
  input  logic            br_valid_i,
  input  ifu_pkg::addr_t  br_target_i,
  input  ifu_pkg::addr_t  br_src_pc_i,
  input  logic            iq_valid_i,
  input  ifu_pkg::inst_t  iq_inst_i,
  input  ifu_pkg::addr_t  iq_pc_i,
  input  logic            deq_i
);

  import ifu_pkg::*;

  int    err_cnt = 0;
  logic  redir;
  logic  first_done_q;
  logic  after_redir_q;
  addr_t redir_tgt_q;
  addr_t last_req_q;   // previous requested address
  logic  req_prev_q;   // a request went out last cycle
  logic  trained_q;
  addr_t br_src_q;
  addr_t br_tgt_q;
  addr_t mdl_q [16];   // requested PCs still expected at decode
  logic [3:0] wr_q;
  logic [3:0] rd_q;
  logic [3:0] mdl_cnt;
  logic  exp_valid;
  addr_t exp_head;
  logic  pop;

  assign redir     = flush_i | trap_valid_i | br_valid_i;
  assign pop       = deq_i & iq_valid_i & ~redir;
  assign exp_head  = mdl_q[rd_q];
  assign mdl_cnt   = wr_q - rd_q;
  // newest request still in flight, not yet queued
  assign exp_valid = (mdl_cnt > 4'(req_prev_q));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      first_done_q  <= 1'b0;
      after_redir_q <= 1'b0;
      redir_tgt_q   <= '0;
      last_req_q    <= '0;
      req_prev_q    <= 1'b0;
      trained_q     <= 1'b0;
      br_src_q      <= '0;
      br_tgt_q      <= '0;
      wr_q          <= '0;
      rd_q          <= '0;
    end else begin
      req_prev_q <= read_req_i;
      if (read_req_i) begin
        first_done_q <= 1'b1;
        last_req_q   <= pc_next_i;
      end
      if (br_valid_i) begin
        trained_q <= 1'b1;
        br_src_q  <= br_src_pc_i;
        br_tgt_q  <= br_target_i;
      end
      if (redir) begin
        // queue emptied and only the target fetch survives
        after_redir_q <= 1'b1;
        if (flush_i) begin
          redir_tgt_q <= PC_RESET_ADDR;
        end else if (trap_valid_i) begin
          redir_tgt_q <= trap_pc_i;
        end else begin
          redir_tgt_q <= br_target_i;
        end
        rd_q          <= '0;
        wr_q          <= read_req_i ? 4'd1 : 4'd0;
        if (read_req_i) mdl_q[0] <= pc_next_i;
      end else begin
        if (pop) after_redir_q <= 1'b0;
        if (read_req_i) begin
          mdl_q[wr_q] <= pc_next_i;
          wr_q        <= wr_q + 4'd1;
        end
        if (pop) rd_q <= rd_q + 4'd1;
      end
    end
  end

  a_reset_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_req_i && !first_done_q) |-> pc_next_i == PC_RESET_ADDR)
    else begin
      err_cnt++;
      $error("ERR reset_fetch expected %h actual %h", PC_RESET_ADDR, $sampled(pc_next_i));
    end

  a_sequential: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_req_i && first_done_q && !redir && !bpu_valid_i) |->
      pc_next_i == last_req_q + 32'd4)
    else begin
      err_cnt++;
      $error("ERR sequential expected %h actual %h",
             $sampled(last_req_q) + 32'd4, $sampled(pc_next_i));
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (stall_i && !redir) |-> !read_req_i)
    else begin
      err_cnt++;
      $error("ERR sequential expected %b actual %b", 1'b0, $sampled(read_req_i));
    end

  a_iq_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
    iq_valid_i == exp_valid)
    else begin
      err_cnt++;
      $error("ERR data_order expected %b actual %b",
             $sampled(exp_valid), $sampled(iq_valid_i));
    end

  a_data: assert property (@(posedge clk) disable iff (!arst_n_i)
    pop |-> iq_inst_i == (iq_pc_i ^ 32'h5A5A_5A5A))
    else begin
      err_cnt++;
      $error("ERR data_order expected %h actual %h",
             $sampled(iq_pc_i) ^ 32'h5A5A_5A5A, $sampled(iq_inst_i));
    end

  a_order: assert property (@(posedge clk) disable iff (!arst_n_i)
    pop |-> iq_pc_i == exp_head)
    else begin
      err_cnt++;
      $error("ERR data_order expected %h actual %h", $sampled(exp_head), $sampled(iq_pc_i));
    end

  a_prio_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_req_i && flush_i && trap_valid_i && br_valid_i) |-> pc_next_i == PC_RESET_ADDR)
    else begin
      err_cnt++;
      $error("ERR priority expected %h actual %h", PC_RESET_ADDR, $sampled(pc_next_i));
    end

  a_prio_trap: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_req_i && !flush_i && trap_valid_i && br_valid_i) |-> pc_next_i == trap_pc_i)
    else begin
      err_cnt++;
      $error("ERR priority expected %h actual %h", $sampled(trap_pc_i), $sampled(pc_next_i));
    end

  a_no_stale: assert property (@(posedge clk) disable iff (!arst_n_i)
    (pop && after_redir_q) |-> iq_pc_i == redir_tgt_q)
    else begin
      err_cnt++;
      $error("ERR no_stale expected %h actual %h", $sampled(redir_tgt_q), $sampled(iq_pc_i));
    end

  // the last trained branch owns its entry
  a_btb_predict: assert property (@(posedge clk) disable iff (!arst_n_i)
    (read_req_i && !redir && trained_q && last_req_q == br_src_q) |->
      pc_next_i == br_tgt_q)
    else begin
      err_cnt++;
      $error("ERR btb_predict expected %h actual %h", $sampled(br_tgt_q), $sampled(pc_next_i));
    end

endmodule

bind ifu_top ifu_assert u_assert (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .read_req_i   (read_req_o),
  .pc_next_i    (pc_next_o),
  .bpu_valid_i  (bpu_valid),
  .stall_i      (stall_i),
  .flush_i      (flush_i),
  .trap_valid_i (trap_valid_i),
  .trap_pc_i    (trap_pc_i),
  .br_valid_i   (br_valid_i),
  .br_target_i  (br_target_i),
  .br_src_pc_i  (br_src_pc_i),
  .iq_valid_i   (iq_valid_o),
  .iq_inst_i    (iq_inst_o),
  .iq_pc_i      (iq_pc_o),
  .deq_i        (deq_i)
);

/* tb/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb;

  import ifu_pkg::*;

  logic  clk;
  logic  arst_n;
  logic  read_req;
  addr_t pc_next;
  inst_t inst_i;
  logic  inst_valid_i;
  logic  iq_valid;
  inst_t iq_inst;
  addr_t iq_pc;
  logic  deq_i;
  logic  stall_i;
  logic  flush_i;
  logic  trap_valid_i;
  addr_t trap_pc_i;
  logic  br_valid_i;
  addr_t br_target_i;
  addr_t br_src_pc_i;
  int    seed = 32'h3ec8fcba;

  tb_clkgen u_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  ifu_top #(.IQ_DEPTH(4), .BTB_ENTRIES(16)) UUT (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .read_req_o   (read_req),
    .pc_next_o    (pc_next),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .iq_valid_o   (iq_valid),
    .iq_inst_o    (iq_inst),
    .iq_pc_o      (iq_pc),
    .deq_i        (deq_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .trap_valid_i (trap_valid_i),
    .trap_pc_i    (trap_pc_i),
    .br_valid_i   (br_valid_i),
    .br_target_i  (br_target_i),
    .br_src_pc_i  (br_src_pc_i)
  );

  // memory word at an address is the address itself, scrambled
  always @(posedge clk) begin
    logic  req_s;
    addr_t addr_s;
    req_s  = read_req;
    addr_s = pc_next;
    #1;
    inst_valid_i = req_s;
    inst_i       = addr_s ^ 32'h5A5A_5A5A;
  end

  task automatic fail_stop(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  always @(posedge clk) begin
    if (UUT.u_assert.err_cnt != 0) fail_stop("an assertion failed");
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_req(input addr_t a, input int limit);
    int n;
    n = 0;
    while (1) begin
      @(negedge clk);
      if (read_req && pc_next == a) break;
      n++;
      if (n > limit) fail_stop($sformatf("no request to %h in %0d cycles", a, limit));
    end
  endtask

  task automatic run_random(input int cycles);
    repeat (cycles) begin
      stall_i = ($random(seed) % 4 == 0);
      deq_i   = $random(seed) & 1;
      step();
    end
    stall_i = 1'b0;
  endtask

  task automatic redirect_pulse(input logic f, input logic t, input logic b,
                                input addr_t tpc, input addr_t src, input addr_t tgt);
    flush_i      = f;
    trap_valid_i = t;
    trap_pc_i    = tpc;
    br_valid_i   = b;
    br_src_pc_i  = src;
    br_target_i  = tgt;
    step();
    flush_i      = 1'b0;
    trap_valid_i = 1'b0;
    br_valid_i   = 1'b0;
  endtask

  initial begin
    int n;
    inst_i       = '0;
    inst_valid_i = 1'b0;
    deq_i        = 1'b0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;
    trap_valid_i = 1'b0;
    trap_pc_i    = '0;
    br_valid_i   = 1'b0;
    br_target_i  = '0;
    br_src_pc_i  = '0;

    n = 0;
    while (arst_n !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > 20) fail_stop("reset never released");
    end
    wait_req(PC_RESET_ADDR, 10);
    step();

    repeat (12) step();  // no pops, queue fills up
    deq_i = 1'b1;
    repeat (12) step();
    run_random(150);

    redirect_pulse(0, 0, 1, '0, 32'h8000_0010, 32'h8000_0100);
    run_random(30);

    // back to the branch source, the BTB steers the fetch
    redirect_pulse(1, 0, 0, '0, '0, '0);
    deq_i = 1'b1;
    wait_req(32'h8000_0010, 40);
    wait_req(32'h8000_0100, 4);
    run_random(30);

    stall_i = 1'b1;
    redirect_pulse(0, 1, 0, 32'h8000_0200, '0, '0);
    run_random(20);
    redirect_pulse(0, 1, 1, 32'h8000_0300, 32'h8000_0400, 32'h8000_0500);
    run_random(20);
    redirect_pulse(1, 1, 1, 32'h8000_0600, 32'h8000_0700, 32'h8000_0800);
    run_random(40);

    repeat (3) step();
    if (UUT.u_assert.err_cnt != 0) begin
      fail_stop("assertion failures at end of run");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 arst_n_o = 1'b1;  // release just after the third edge
  end

endmodule
